// File: Makefile
VERILATOR ?= verilator
TOP       ?= risc_toy_tb
RTL_TOP   ?= risc_toy
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_MSG)"; then \
	    exit 0; else exit 1; fi

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
+incdir+testbench
logic/risc_pkg.sv
logic/risc_fetch.sv
logic/risc_regfile.sv
logic/risc_decode.sv
logic/risc_execute.sv
logic/risc_writeback.sv
logic/risc_toy.sv
testbench/risc_toy_tb.sv

// File: logic/risc_decode.sv
//////////////////////////////
// decode stage, register read, load-use stall, decode/execute register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_decode import risc_pkg::*; (
    input  wire logic     CLK,
    input  wire logic     RSTN,
    input  wire instr_u   INSTR,
    input  wire logic     fetch_valid,
    input  wire logic     flush,           // taken branch squashes this slot
    input  wire wb_t      wb,
    input  wire reg_idx_t ex_load_dest,
    input  wire logic     ex_load_valid,
    output logic          stall,
    output dec_t          dec
);

    instr_u   cur, hold_word;
    logic     cur_valid, held_r;
    logic     use_a, use_b, wr, sext;
    reg_idx_t idx_a, idx_b;
    word_t    rd_a, rd_b, imm;

    // INSTR is gone after a stall, replay the saved word
    assign cur       = held_r ? hold_word : INSTR;
    assign cur_valid = held_r || fetch_valid;

    assign idx_a = cur.r.rb;                               // base, target or rb
    assign idx_b = (cur.r.op == OP_ST) ? cur.r.ra : cur.r.rc; // store data on b

    always_comb begin
        use_a = 1'b0;
        use_b = 1'b0;
        wr    = 1'b0;
        sext  = 1'b0;
        case (cur.r.op)
            OP_ADDI, OP_ANDI, OP_ORI: begin
                use_a = 1'b1;
                wr    = 1'b1;
                sext  = 1'b1;
            end
            OP_MOVI: begin
                wr   = 1'b1;
                sext = 1'b1;
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                use_a = 1'b1;
                use_b = 1'b1;
                wr    = 1'b1;
            end
            OP_NEG, OP_NOT: begin
                use_b = 1'b1;                               // single operand is rc
                wr    = 1'b1;
            end
            OP_LSR, OP_ASR, OP_SHL, OP_ROR: begin
                use_a = 1'b1;
                use_b = cur.r.sh_reg;
                wr    = 1'b1;
            end
            OP_BR: begin
                use_a = 1'b1;
                use_b = 1'b1;
            end
            OP_LD: begin
                use_a = (cur.i.rb != BASE_NONE);
                wr    = 1'b1;
            end
            OP_ST: begin
                use_a = (cur.i.rb != BASE_NONE);
                use_b = 1'b1;
            end
            default: ;                                      // no-op
        endcase
    end

    // shifts carry flag and amount in the low bits of a zero-extended imm
    assign imm = sext ? {{15{cur.i.imm[16]}}, cur.i.imm} : {15'd0, cur.i.imm};

    assign stall = cur_valid && !flush && ex_load_valid &&
                   ((use_a && idx_a == ex_load_dest) || (use_b && idx_b == ex_load_dest));

    risc_regfile regfile_i (
        .CLK      (CLK),
        .RSTN     (RSTN),
        .wb       (wb),
        .rd_idx_a (idx_a),
        .rd_idx_b (idx_b),
        .rd_a     (rd_a),
        .rd_b     (rd_b)
    );

    always_ff @(posedge CLK) begin
        if (stall)
            hold_word <= cur;                               // payload only
    end

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            held_r <= 1'b0;
            dec    <= '0;
        end else begin
            held_r <= stall;
            if (stall || flush || !cur_valid) begin
                dec <= '0;                                  // bubble
            end else begin
                dec.valid <= 1'b1;
                dec.op    <= cur.r.op;
                dec.dest  <= cur.r.ra;
                dec.wr    <= wr;
                dec.opa   <= rd_a;
                dec.opb   <= rd_b;
                dec.src_a <= idx_a;
                dec.src_b <= idx_b;
                dec.imm   <= imm;
                dec.cond  <= cur.b.cond;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/risc_execute.sv
//////////////////////////////
// execute stage, forwarding, ALU, branch, and the data port request
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_execute import risc_pkg::*; (
    input  wire logic  CLK,
    input  wire logic  RSTN,
    input  wire dec_t  dec,
    input  wire wb_t   wb,
    output logic       redirect,
    output waddr_t     target,
    output reg_idx_t   ex_load_dest,
    output logic       ex_load_valid,
    output mem_t       mem,
    output logic       DREQ,
    output logic       DRW,
    output waddr_t     DADDR,
    output word_t      DWDATA
);

    word_t      a, b, base, addr, alu;
    logic [4:0] sh;
    logic [63:0] rot;
    logic       taken;
    mem_t       mem_q;
    logic       store_q;
    word_t      st_data_q;

    // newest value wins and loads never forward from the memory stage
    function automatic word_t fwd(reg_idx_t idx, word_t val, mem_t m, wb_t w);
        if (m.valid && m.wr && !m.load && m.dest == idx)
            return m.result;
        else if (w.we && w.dest == idx)
            return w.data;
        return val;
    endfunction

    function automatic logic cond_ok(cond_e c, word_t v);
        case (c)
            COND_ALWAYS:  return 1'b1;
            COND_ZERO:    return v == '0;
            COND_NONZERO: return v != '0;
            COND_GEZ:     return !v[31];
            COND_NEG:     return v[31];
            default:      return 1'b0;                      // never
        endcase
    endfunction

    assign a = fwd(dec.src_a, dec.opa, mem_q, wb);
    assign b = fwd(dec.src_b, dec.opb, mem_q, wb);

    assign sh   = dec.imm[5] ? b[4:0] : dec.imm[4:0];       // register or imm amount
    assign rot  = {a, a} >> sh;
    assign base = (dec.src_a == BASE_NONE) ? '0 : a;
    assign addr = base + dec.imm;                           // byte address

    always_comb begin
        case (dec.op)
            OP_ADDI: alu = a + dec.imm;
            OP_ANDI: alu = a & dec.imm;
            OP_ORI:  alu = a | dec.imm;
            OP_MOVI: alu = dec.imm;
            OP_ADD:  alu = a + b;
            OP_SUB:  alu = a - b;
            OP_NEG:  alu = -b;
            OP_NOT:  alu = ~b;
            OP_AND:  alu = a & b;
            OP_OR:   alu = a | b;
            OP_XOR:  alu = a ^ b;
            OP_LSR:  alu = a >> sh;
            OP_ASR:  alu = $signed(a) >>> sh;
            OP_SHL:  alu = a << sh;
            OP_ROR:  alu = rot[31:0];
            default: alu = addr;                            // ld/st address
        endcase
    end

    // branch resolves here and rb holds a byte address
    assign taken    = dec.valid && dec.op == OP_BR && cond_ok(dec.cond, b);
    assign redirect = taken;
    assign target   = a[31:2];

    assign ex_load_valid = dec.valid && dec.op == OP_LD;
    assign ex_load_dest  = dec.dest;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            mem_q   <= '0;
            store_q <= 1'b0;
        end else begin
            mem_q.valid  <= dec.valid;
            mem_q.wr     <= dec.valid && dec.wr;
            mem_q.dest   <= dec.dest;
            mem_q.load   <= ex_load_valid;
            mem_q.result <= alu;
            store_q      <= dec.valid && dec.op == OP_ST;
        end
    end

    always_ff @(posedge CLK) begin
        st_data_q <= b;                                     // forwarded store data
    end

    assign mem    = mem_q;
    assign DREQ   = mem_q.load || store_q;
    assign DRW    = store_q;
    assign DADDR  = mem_q.result[31:2];
    assign DWDATA = st_data_q;

    // a store request never comes from a register-writing entry
    a_drw_req : assert property (@(posedge CLK) disable iff (!RSTN)
        DRW |-> !mem_q.wr);

endmodule

`default_nettype wire

// File: logic/risc_fetch.sv
//////////////////////////////
// program counter and instruction request
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_fetch import risc_pkg::*; #(
    parameter waddr_t RESET_ADDR = '0
) (
    input  wire logic   CLK,
    input  wire logic   RSTN,
    input  wire logic   stall,             // load-use hold from decode
    input  wire logic   redirect,          // taken branch in execute
    input  wire waddr_t target,
    output logic        IREQ,
    output waddr_t      IADDR,
    output logic        fetch_valid        // INSTR of this cycle is usable
);

    waddr_t pc;

    assign IREQ  = !stall;                 // no request while held
    assign IADDR = pc;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            pc          <= RESET_ADDR;
            fetch_valid <= 1'b0;
        end else begin
            if (redirect)
                pc <= target;              // branch wins over stall
            else if (!stall)
                pc <= pc + 30'd1;
            fetch_valid <= IREQ && !redirect; // word in flight voided by branch
        end
    end

    // held address must stay put until decode releases it
    a_hold_addr : assert property (@(posedge CLK) disable iff (!RSTN)
        stall |=> $stable(IADDR));

endmodule

`default_nettype wire

// File: logic/risc_pkg.sv
//////////////////////////////
// shared types for the toy RISC core, imported by every stage
//////////////////////////////
`default_nettype none

package risc_pkg;

    typedef logic [31:0] word_t;           // data word
    typedef logic [29:0] waddr_t;          // byte address without its low two bits
    typedef logic [4:0]  reg_idx_t;        // register index

    localparam reg_idx_t BASE_NONE = 5'd31; // ld/st base field meaning no base

    typedef enum logic [4:0] {
        OP_ADDI = 5'd0,  OP_ANDI = 5'd1,  OP_ORI = 5'd2,  OP_MOVI = 5'd3,
        OP_ADD  = 5'd4,  OP_SUB  = 5'd5,  OP_NEG = 5'd6,  OP_NOT  = 5'd7,
        OP_AND  = 5'd8,  OP_OR   = 5'd9,  OP_XOR = 5'd10, OP_LSR  = 5'd11,
        OP_ASR  = 5'd12, OP_SHL  = 5'd13, OP_ROR = 5'd14, OP_BR   = 5'd15,
        OP_LD   = 5'd19, OP_ST   = 5'd21
    } opcode_e;                            // anything else runs as a no-op

    typedef enum logic [2:0] {
        COND_NEVER   = 3'd0,
        COND_ALWAYS  = 3'd1,
        COND_ZERO    = 3'd2,
        COND_NONZERO = 3'd3,
        COND_GEZ     = 3'd4,               // signed >= 0
        COND_NEG     = 3'd5                // 6 and 7 never taken
    } cond_e;

    //////////////////////////////
    // instruction formats
    //////////////////////////////
    typedef struct packed {
        opcode_e     op;
        reg_idx_t    ra;                   // destination
        reg_idx_t    rb;
        reg_idx_t    rc;
        logic [5:0]  rsvd;
        logic        sh_reg;               // shift amount from rc
        logic [4:0]  shamt;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     op;
        reg_idx_t    ra;
        reg_idx_t    rb;                   // base for ld/st
        logic [16:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     op;
        reg_idx_t    ra;                   // unused by br
        reg_idx_t    rb;                   // target register
        reg_idx_t    rc;                   // tested register
        logic [8:0]  rsvd;
        cond_e       cond;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } instr_u;

    //////////////////////////////
    // stage bundles
    //////////////////////////////
    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t dest;
        logic     wr;                      // writes dest
        word_t    opa;                     // R[rb]
        word_t    opb;                     // R[rc], or R[ra] for st
        reg_idx_t src_a;
        reg_idx_t src_b;
        word_t    imm;
        cond_e    cond;
    } dec_t;

    typedef struct packed {
        logic     valid;
        logic     wr;
        reg_idx_t dest;
        logic     load;
        word_t    result;                  // alu result or ld/st byte address
    } mem_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

// File: logic/risc_regfile.sv
//////////////////////////////
// 32 x 32 register file, 2 read / 1 write, write-through
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_regfile import risc_pkg::*; (
    input  wire logic     CLK,
    input  wire logic     RSTN,
    input  wire wb_t      wb,
    input  wire reg_idx_t rd_idx_a,
    input  wire reg_idx_t rd_idx_b,
    output word_t         rd_a,
    output word_t         rd_b
);

    word_t regs [32];

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.we) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // same-cycle write passes straight to the readers
    assign rd_a = (wb.we && wb.dest == rd_idx_a) ? wb.data : regs[rd_idx_a];
    assign rd_b = (wb.we && wb.dest == rd_idx_b) ? wb.data : regs[rd_idx_b];

endmodule

`default_nettype wire

// File: logic/risc_toy.sv
//////////////////////////////
// five-stage toy RISC core, memories sit outside on IREQ/DREQ ports
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_toy import risc_pkg::*; #(
    parameter waddr_t RESET_ADDR = '0
) (
    input  wire logic  CLK,
    input  wire logic  RSTN,
    output logic       IREQ,
    output waddr_t     IADDR,
    input  wire word_t INSTR,
    output logic       DREQ,
    output logic       DRW,
    output waddr_t     DADDR,
    output word_t      DWDATA,
    input  wire word_t DRDATA
);

    logic     stall, redirect, fetch_valid, ex_load_valid;
    waddr_t   target;
    reg_idx_t ex_load_dest;
    dec_t     dec;
    mem_t     mem;
    wb_t      wb;

    risc_fetch #(.RESET_ADDR(RESET_ADDR)) fetch_i (
        .CLK         (CLK),
        .RSTN        (RSTN),
        .stall       (stall),
        .redirect    (redirect),
        .target      (target),
        .IREQ        (IREQ),
        .IADDR       (IADDR),
        .fetch_valid (fetch_valid)
    );

    risc_decode decode_i (
        .CLK           (CLK),
        .RSTN          (RSTN),
        .INSTR         (INSTR),
        .fetch_valid   (fetch_valid),
        .flush         (redirect),         // branch squashes the decode slot
        .wb            (wb),
        .ex_load_dest  (ex_load_dest),
        .ex_load_valid (ex_load_valid),
        .stall         (stall),
        .dec           (dec)
    );

    risc_execute execute_i (
        .CLK           (CLK),
        .RSTN          (RSTN),
        .dec           (dec),
        .wb            (wb),
        .redirect      (redirect),
        .target        (target),
        .ex_load_dest  (ex_load_dest),
        .ex_load_valid (ex_load_valid),
        .mem           (mem),
        .DREQ          (DREQ),
        .DRW           (DRW),
        .DADDR         (DADDR),
        .DWDATA        (DWDATA)
    );

    risc_writeback writeback_i (
        .CLK    (CLK),
        .RSTN   (RSTN),
        .mem    (mem),
        .DRDATA (DRDATA),
        .wb     (wb)
    );

endmodule

`default_nettype wire

// File: logic/risc_writeback.sv
//////////////////////////////
// memory/writeback register and result select
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_writeback import risc_pkg::*; (
    input  wire logic  CLK,
    input  wire logic  RSTN,
    input  wire mem_t  mem,
    input  wire word_t DRDATA,             // one cycle after the load request
    output wb_t        wb
);

    mem_t q;

    always_ff @(posedge CLK or negedge RSTN) begin
        if (!RSTN)
            q <= '0;
        else
            q <= mem;
    end

    assign wb.we   = q.valid && q.wr;
    assign wb.dest = q.dest;
    assign wb.data = q.load ? DRDATA : q.result; // load data arrives now

    // write flag only ever set on a valid entry
    a_we_valid : assert property (@(posedge CLK) disable iff (!RSTN)
        q.wr |-> q.valid);

endmodule

`default_nettype wire

// File: testbench/risc_toy_model.svh
//////////////////////////////
// instruction-set model, included in the testbench module to predict stores
//////////////////////////////
`ifndef RISC_TOY_MODEL_SVH
`define RISC_TOY_MODEL_SVH

// power-on contents of a data word, mixes every address bit
function automatic word_t init_word(waddr_t wa);
    word_t w;
    w = {2'b10, wa};
    return w ^ (w * 32'h2545_f491) ^ {wa[14:0], wa[29:13]};
endfunction

// runs imem from word 0 until the self branch, fills exp_addr and exp_data
function automatic void predict_stores();
    word_t      r [32];
    word_t      dm [waddr_t];
    instr_u     w;
    int         pc;
    int         steps;
    word_t      a, b, imm_s, imm_z, addr;
    logic [4:0] sh;
    waddr_t     wa;
    logic       taken;
    for (int i = 0; i < 32; i++)
        r[i] = '0;                                   // core clears regs on reset
    exp_addr.delete();
    exp_data.delete();
    model_done = 1'b0;
    pc = 0;
    for (steps = 0; steps < 4000; steps++) begin
        w     = imem[pc[7:0]];
        a     = r[w.r.rb];
        b     = r[w.r.rc];
        imm_s = {{15{w.i.imm[16]}}, w.i.imm};
        imm_z = {15'd0, w.i.imm};
        sh    = w.r.sh_reg ? b[4:0] : w.r.shamt;
        addr  = ((w.i.rb == BASE_NONE) ? 32'd0 : a) + imm_z; // byte address
        wa    = addr[31:2];
        pc    = pc + 1;
        case (w.r.op)
            OP_ADDI: r[w.r.ra] = a + imm_s;
            OP_ANDI: r[w.r.ra] = a & imm_s;
            OP_ORI:  r[w.r.ra] = a | imm_s;
            OP_MOVI: r[w.r.ra] = imm_s;
            OP_ADD:  r[w.r.ra] = a + b;
            OP_SUB:  r[w.r.ra] = a - b;
            OP_NEG:  r[w.r.ra] = '0 - b;
            OP_NOT:  r[w.r.ra] = ~b;
            OP_AND:  r[w.r.ra] = a & b;
            OP_OR:   r[w.r.ra] = a | b;
            OP_XOR:  r[w.r.ra] = a ^ b;
            OP_LSR:  r[w.r.ra] = a >> sh;
            OP_ASR:  r[w.r.ra] = $signed(a) >>> sh;
            OP_SHL:  r[w.r.ra] = a << sh;
            OP_ROR:  r[w.r.ra] = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
            OP_LD:   r[w.r.ra] = dm.exists(wa) ? dm[wa] : init_word(wa);
            OP_ST: begin
                dm[wa] = r[w.r.ra];                  // ra carries store data
                exp_addr.push_back(wa);
                exp_data.push_back(r[w.r.ra]);
            end
            OP_BR: begin
                case (w.b.cond)
                    COND_ALWAYS:  taken = 1'b1;
                    COND_ZERO:    taken = (b == '0);
                    COND_NONZERO: taken = (b != '0);
                    COND_GEZ:     taken = !b[31];
                    COND_NEG:     taken = b[31];
                    default:      taken = 1'b0;
                endcase
                if (taken && {2'b00, a[31:2]} == pc - 1) begin
                    model_done = 1'b1;               // branch to itself ends it
                    break;
                end
                if (taken)
                    pc = {2'b00, a[31:2]};
            end
            default: ;                               // no-op codes
        endcase
    end
endfunction

`endif

// File: testbench/risc_toy_tb.sv
//////////////////////////////
// random-program testbench for the toy RISC core with stores checked against the ISA model
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module risc_toy_tb import risc_pkg::*;;

    localparam waddr_t RESET_ADDR = '0;
    localparam int     N_TESTS    = 20;
    localparam int     N_ITEMS    = 50;          // fits 256 words at 4 per item

    logic   CLK, RSTN, IREQ, DREQ, DRW;
    waddr_t IADDR, DADDR;
    word_t  INSTR, DWDATA, DRDATA;

    word_t    imem [256];
    word_t    dmem [waddr_t];
    waddr_t   exp_addr [$];
    word_t    exp_data [$];
    logic     model_done;
    int       plen, n_exp, n_seen, test_no, errors, fails;
    reg_idx_t hist [3];                          // recent dests feeding dependencies
    logic     s_ireq, s_dreq, s_drw;
    waddr_t   s_iaddr, s_daddr;

    `include "risc_toy_model.svh"

    risc_toy #(.RESET_ADDR(RESET_ADDR)) risc_toy_i (
        .CLK(CLK), .RSTN(RSTN), .IREQ(IREQ), .IADDR(IADDR), .INSTR(INSTR),
        .DREQ(DREQ), .DRW(DRW), .DADDR(DADDR), .DWDATA(DWDATA), .DRDATA(DRDATA)
    );

    always #4 CLK = ~CLK;                        // 8 ns period

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic check_addr(string name, waddr_t exp, waddr_t act);
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("** Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    //////////////////////////////
    // memories and store compare
    //////////////////////////////
    always @(negedge CLK) begin
        s_ireq  = IREQ;                          // mid-cycle sample of settled outputs
        s_iaddr = IADDR;
        s_dreq  = DREQ;
        s_drw   = DRW;
        s_daddr = DADDR;
        if (RSTN && DREQ && DRW) begin
            if (exp_addr.size() == 0) begin
                fails++;
                $display("test %0d made a store the model does not expect, addr %h data %h",
                         test_no, DADDR, DWDATA);
            end else begin
                check_addr($sformatf("test %0d store %0d addr", test_no, n_seen),
                           exp_addr.pop_front(), DADDR);
                check_word($sformatf("test %0d store %0d data", test_no, n_seen),
                           exp_data.pop_front(), DWDATA);
            end
            n_seen++;
            dmem[DADDR] = DWDATA;
        end
    end

    always @(posedge CLK) begin
        #1;
        if (s_ireq)
            INSTR = imem[s_iaddr[7:0]];          // answers one cycle later
        if (s_dreq && !s_drw)
            DRDATA = dmem.exists(s_daddr) ? dmem[s_daddr] : init_word(s_daddr);
    end

    //////////////////////////////
    // program building
    //////////////////////////////
    function automatic word_t i_word(logic [4:0] op, reg_idx_t ra, reg_idx_t rb,
                                     logic [16:0] imm);
        return {op, ra, rb, imm};
    endfunction

    function automatic word_t r_word(logic [4:0] op, reg_idx_t ra, reg_idx_t rb,
                                     reg_idx_t rc, logic sh_reg, logic [4:0] shamt);
        return {op, ra, rb, rc, 6'd0, sh_reg, shamt};
    endfunction

    function automatic word_t br_word(reg_idx_t rb, reg_idx_t rc, logic [2:0] cond);
        return {5'(OP_BR), 5'd0, rb, rc, 9'd0, cond};
    endfunction

    function automatic logic [16:0] rand_imm();
        word_t t;
        t = $urandom;
        return t[16:0];
    endfunction

    function automatic reg_idx_t rand_reg();
        return 5'($urandom_range(1, 12));        // r20, r21, r30 stay addresses
    endfunction

    task automatic put(word_t w);
        imem[plen[7:0]] = w;
        plen++;
    endtask

    task automatic put_store(reg_idx_t src);
        reg_idx_t base;
        base = ($urandom % 2) ? BASE_NONE : 5'd20;
        put(i_word(OP_ST, src, base, 17'($urandom_range(0, 63) * 4)));
    endtask

    task automatic make_program();
        reg_idx_t d, s1, s2;
        int       kind;
        for (int i = 0; i < 256; i++)
            imem[i] = {5'd31, 27'd0};            // no-op fill past the end
        plen = 0;
        for (int i = 1; i <= 12; i++)
            put(i_word(OP_MOVI, 5'(i), 5'd0, rand_imm()));
        put(i_word(OP_MOVI, 5'd20, 5'd0, 17'h400)); // second data region
        for (int i = 0; i < 3; i++)
            hist[i] = rand_reg();
        repeat (N_ITEMS) begin
            kind = $urandom_range(0, 6);
            d    = rand_reg();
            s1   = ($urandom % 2) ? hist[$urandom_range(0, 2)] : rand_reg();
            s2   = ($urandom % 2) ? hist[$urandom_range(0, 2)] : rand_reg();
            case (kind)
                0: put(i_word(5'($urandom_range(0, 3)), d, s1, rand_imm()));
                1: put(r_word(5'($urandom_range(4, 10)), d, s1, s2, 1'b0, 5'd0));
                2: put(r_word(5'($urandom_range(11, 14)), d, s1, s2, 1'($urandom),
                              5'($urandom)));
                3: begin
                    put(i_word(OP_LD, s1, ($urandom % 2) ? BASE_NONE : 5'd20,
                               17'($urandom_range(0, 63) * 4)));
                    put(r_word(OP_ADD, d, s1, s2, 1'b0, 5'd0)); // load-use
                end
                4: put_store(s1);
                5: begin
                    put(i_word(OP_MOVI, 5'd21, 5'd0, 17'((plen + 4) * 4)));
                    put(br_word(5'd21, s1, 3'($urandom)));
                    put_store(s2);                   // skipped when taken
                    put_store(s1);
                end
                default: put({5'd16, 27'($urandom)}); // undefined code
            endcase
            if (kind < 4)
                put_store(d);
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = d;
        end
        for (int i = 1; i <= 12; i++)
            put(i_word(OP_ST, 5'(i), BASE_NONE, 17'((64 + i) * 4))); // register dump
        put(i_word(OP_MOVI, 5'd30, 5'd0, 17'((plen + 1) * 4)));
        put(br_word(5'd30, 5'd0, COND_ALWAYS));  // park here
    endtask

    //////////////////////////////
    // sequencing
    //////////////////////////////
    task automatic reset_dut();
        @(posedge CLK);
        #1 RSTN = 1'b0;
        dmem.delete();
        n_seen = 0;
        repeat (10) @(posedge CLK);
        #1 RSTN = 1'b1;
        check_bit("reset IREQ", 1'b1, IREQ);     // still reset state until next edge
        check_addr("reset IADDR", RESET_ADDR, IADDR);
        check_bit("reset DREQ", 1'b0, DREQ);
        check_bit("reset DRW", 1'b0, DRW);
    endtask

    task automatic wait_stores();
        int cyc;
        cyc = 0;
        while (n_seen < n_exp && cyc < 5000) begin
            @(posedge CLK);
            cyc++;
        end
        if (n_seen < n_exp) begin
            fails++;
            $display("timeout in test %0d, only %0d of %0d stores seen", test_no, n_seen, n_exp);
        end
        cyc = 0;
        while (cyc < 40) begin                   // catch stray stores
            @(posedge CLK);
            cyc++;
        end
    endtask

    initial begin
        CLK    = 1'b0;
        RSTN   = 1'b0;
        INSTR  = '0;
        DRDATA = '0;
        errors = 0;
        fails  = 0;
        n_seen = 0;
        void'($urandom(32'hceca));
        for (test_no = 0; test_no < N_TESTS; test_no++) begin
            make_program();
            predict_stores();
            n_exp = exp_addr.size();
            if (!model_done) begin
                fails++;
                $display("model did not reach the final branch in test %0d", test_no);
            end
            reset_dut();
            wait_stores();
        end
        $display("errors: %0d value, %0d other, over %0d tests", errors, fails, N_TESTS);
        if (errors == 0 && fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
